//--- hw/fcuPkg.sv
`default_nettype none

package fcuPkg;

    // ========================================
    // Widths
    // ========================================

    // Operand and result bus width
    localparam int dataWidth = 64;
    // Program counter and fetch target width
    localparam int addrWidth = 32;
    // Full instruction word, short forms live in the low 32 bits
    localparam int instrWidth = 48;

    // ========================================
    // Instruction fields
    // ========================================

    // Major opcode
    localparam int opLsb = 0;
    localparam int opMsb = 5;
    // Length flag, set for a 6-byte instruction
    localparam int longBit = 6;
    // BBc sub-function select
    localparam int subLsb = 17;
    localparam int subMsb = 19;
    // BRK cause code
    localparam int causeLsb = 8;
    localparam int causeMsb = 15;
    // Branch and JAL displacement, signed
    localparam int dispLsb = 32;
    localparam int dispMsb = 47;
    // CALL absolute target
    localparam int callLsb = 16;
    localparam int callMsb = 47;

    // Result value driven when the function is undefined
    localparam logic [dataWidth-1:0] fillPattern = {(dataWidth / 8){8'hCC}};

    // ========================================
    // Encodings
    // ========================================

    // Flow-control opcodes, anything else is illegal here
    typedef enum logic [5:0] {
        opBrk  = 6'h00,
        opRex  = 6'h0D,
        opWait = 6'h0E,
        opJal  = 6'h18,
        opCall = 6'h19,
        opBbc  = 6'h26,
        opRet  = 6'h29
    } fcuOpcode;

    // BBc sub-functions handled by this unit
    typedef enum logic [2:0] {
        subIbne = 3'd6,
        subDbnz = 3'd7
    } bbcSubFunc;

    // Operating levels, user must stay at 3
    typedef enum logic [1:0] {
        olMachine = 2'd0,
        olHyper   = 2'd1,
        olSuper   = 2'd2,
        olUser    = 2'd3
    } opLevel;

    // Decoded function, produced once in control
    typedef enum logic [3:0] {
        fnBrk     = 4'd0,
        fnIbne    = 4'd1,
        fnDbnz    = 4'd2,
        fnLink    = 4'd3,
        fnRet     = 4'd4,
        fnRex     = 4'd5,
        fnWait    = 4'd6,
        fnIllegal = 4'd7
    } fcuFunc;

endpackage

`default_nettype wire

//--- hw/fcuOpIf.sv
`timescale 1ns/10ps
`default_nettype none

interface fcuOpIf
    import fcuPkg::*;
();

    // Decoded function of the instruction in stage one
    fcuFunc func;
    // Raw instruction, datapaths still need a few fields
    logic [instrWidth-1:0] instr;

    // Operands captured at issue
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] i;
    logic [dataWidth-1:0] lr;
    logic [dataWidth-1:0] tvec;
    logic [dataWidth-1:0] waitCtr;
    logic [addrWidth-1:0] pc;

    // Interrupt mask and current operating level
    logic [2:0] im;
    opLevel ol;

    // Control owns stage one
    modport ctrl (output func, instr, a, i, lr, tvec, waitCtr, pc, im, ol);

    // Datapaths only look
    modport dp (input func, instr, a, i, lr, tvec, waitCtr, pc, im, ol);

endinterface

`default_nettype wire

//--- hw/fcuControl.sv
`timescale 1ns/10ps
`default_nettype none

module fcuControl
    import fcuPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  issue,
    input  wire logic [instrWidth-1:0] instr,
    input  wire logic [dataWidth-1:0]  a,
    input  wire logic [dataWidth-1:0]  i,
    input  wire logic [dataWidth-1:0]  lr,
    input  wire logic [dataWidth-1:0]  tvec,
    input  wire logic [dataWidth-1:0]  waitCtr,
    input  wire logic [addrWidth-1:0]  pc,
    input  wire logic [2:0]            im,
    input  wire opLevel                ol,
    fcuOpIf.ctrl                       opBus,
    input  wire logic [dataWidth-1:0]  calcBus,
    input  wire logic                  branchTaken,
    input  wire logic [addrWidth-1:0]  nextTarget,
    output logic                       done,
    output logic [dataWidth-1:0]       result,
    output logic                       taken,
    output logic [addrWidth-1:0]       target,
    output logic                       illegal
);

    fcuOpcode  opcode;
    bbcSubFunc subFunc;
    fcuFunc    decFunc;
    logic      stage1Valid;

    // ========================================
    // Decode
    // ========================================

    assign opcode  = fcuOpcode'(instr[opMsb:opLsb]);
    assign subFunc = bbcSubFunc'(instr[subMsb:subLsb]);

    always_comb
    begin
        case (opcode)
            opBrk: decFunc = fnBrk;
            opBbc:
            begin
                // Only the increment and decrement forms belong here
                case (subFunc)
                    subIbne: decFunc = fnIbne;
                    subDbnz: decFunc = fnDbnz;
                    default: decFunc = fnIllegal;
                endcase
            end
            // JAL and CALL differ only in target, datapath sorts that out
            opJal, opCall: decFunc = fnLink;
            opRet: decFunc = fnRet;
            // No privilege to return from at user level
            opRex: decFunc = (ol == olUser) ? fnIllegal : fnRex;
            opWait: decFunc = fnWait;
            default: decFunc = fnIllegal;
        endcase
    end

    // ========================================
    // Stage one
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!rstN)
            stage1Valid <= 1'b0;
        else
            stage1Valid <= issue;
    end

    // Operand bundle, only loaded on issue
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            opBus.func    <= decFunc;
            opBus.instr   <= instr;
            opBus.a       <= a;
            opBus.i       <= i;
            opBus.lr      <= lr;
            opBus.tvec    <= tvec;
            opBus.waitCtr <= waitCtr;
            opBus.pc      <= pc;
            opBus.im      <= im;
            opBus.ol      <= ol;
        end
    end

    // ========================================
    // Stage two
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            done    <= 1'b0;
            result  <= '0;
            taken   <= 1'b0;
            target  <= '0;
            illegal <= 1'b0;
        end
        else
        begin
            // One pulse per valid stage-one slot
            done <= stage1Valid;
            if (stage1Valid)
            begin
                result  <= calcBus;
                taken   <= branchTaken;
                target  <= nextTarget;
                illegal <= (opBus.func == fnIllegal);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fcuCalc.sv
`timescale 1ns/10ps
`default_nettype none

module fcuCalc
    import fcuPkg::*;
(
    fcuOpIf.dp                   opBus,
    output logic [dataWidth-1:0] bus
);

    logic [addrWidth-1:0] linkAddr;
    logic [addrWidth-1:0] rexReturn;
    logic [causeMsb-causeLsb:0] cause;

    // Return address skips the whole instruction, 4 or 6 bytes
    assign linkAddr = opBus.pc + (opBus.instr[longBit] ? addrWidth'(6) : addrWidth'(4));

    // REX always leaves the next sequential address on the bus
    assign rexReturn = opBus.pc + addrWidth'(4);

    // BRK cause code
    assign cause = opBus.instr[causeMsb:causeLsb];

    always_comb
    begin
        case (opBus.func)
            fnBrk:
                bus = dataWidth'(cause);
            // Updated counter goes back to the register file
            fnIbne:
                bus = opBus.a + dataWidth'(1);
            fnDbnz:
                bus = opBus.a - dataWidth'(1);
            fnLink:
                bus = dataWidth'(linkAddr);
            // Stack pointer adjust
            fnRet:
                bus = opBus.a + opBus.i;
            fnRex:
                bus = dataWidth'(rexReturn);
            // Reports whether the wait has run out
            fnWait:
                bus = (opBus.waitCtr == dataWidth'(1)) ? dataWidth'(1) : '0;
            // Illegal and unused codes
            default:
                bus = fillPattern;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fcuBranchEval.sv
`timescale 1ns/10ps
`default_nettype none

module fcuBranchEval
    import fcuPkg::*;
(
    fcuOpIf.dp   opBus,
    output logic taken
);

    logic [dataWidth-1:0] aInc;
    logic [dataWidth-1:0] aDec;

    // Full-width counter updates, wrap is intended
    assign aInc = opBus.a + dataWidth'(1);
    assign aDec = opBus.a - dataWidth'(1);

    always_comb
    begin
        case (opBus.func)
            // Loop while the counter has not reached the limit
            fnIbne:
                taken = (aInc != opBus.i);
            // Loop until the counter hits zero
            fnDbnz:
                taken = (aDec != '0);
            // Keep waiting until the count is down to one
            fnWait:
                taken = (opBus.waitCtr != dataWidth'(1));
            // Unconditional redirects
            fnBrk, fnLink, fnRet, fnRex:
                taken = 1'b1;
            default:
                taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fcuTarget.sv
`timescale 1ns/10ps
`default_nettype none

module fcuTarget
    import fcuPkg::*;
(
    fcuOpIf.dp                   opBus,
    output logic [addrWidth-1:0] target
);

    logic [addrWidth-1:0] disp;
    logic [1:0]           olInv;
    logic                 rexToVec;
    logic                 isCall;

    // Sign-extend the 16-bit displacement to address width
    assign disp = {{(addrWidth - (dispMsb - dispLsb + 1)){opBus.instr[dispMsb]}},
                   opBus.instr[dispMsb:dispLsb]};

    // Inverse taken at two bits so any non-user level gives a nonzero limit
    assign olInv = ~opBus.ol;

    // Pending interrupt below the level limit sends REX to the vector
    assign rexToVec = (opBus.im < {1'b0, olInv});

    // JAL and CALL share fnLink
    assign isCall = (fcuOpcode'(opBus.instr[opMsb:opLsb]) == opCall);

    always_comb
    begin
        case (opBus.func)
            fnIbne, fnDbnz:
                target = opBus.pc + disp;
            fnLink:
            begin
                if (isCall)
                    target = opBus.instr[callMsb:callLsb];
                else
                    target = opBus.a[addrWidth-1:0] + disp;
            end
            fnRet:
                target = opBus.lr[addrWidth-1:0];
            fnBrk:
                target = opBus.tvec[addrWidth-1:0];
            fnRex:
                target = rexToVec ? opBus.tvec[addrWidth-1:0] : opBus.pc + addrWidth'(4);
            // Refetch the WAIT itself
            fnWait:
                target = opBus.pc;
            default:
                target = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fcuTop.sv
`timescale 1ns/10ps
`default_nettype none

module fcuTop
    import fcuPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  issue,
    input  wire logic [instrWidth-1:0] instr,
    input  wire logic [dataWidth-1:0]  a,
    input  wire logic [dataWidth-1:0]  i,
    input  wire logic [dataWidth-1:0]  lr,
    input  wire logic [dataWidth-1:0]  tvec,
    input  wire logic [dataWidth-1:0]  waitCtr,
    input  wire logic [addrWidth-1:0]  pc,
    input  wire logic [2:0]            im,
    input  wire opLevel                ol,
    output logic                       done,
    output logic [dataWidth-1:0]       result,
    output logic                       taken,
    output logic [addrWidth-1:0]       target,
    output logic                       illegal
);

    // Datapath results back to control
    logic [dataWidth-1:0] calcBus;
    logic                 branchTaken;
    logic [addrWidth-1:0] nextTarget;

    // Stage-one operand bundle
    fcuOpIf opBus ();

    // ========================================
    // Control and pipeline registers
    // ========================================

    fcuControl control (
        .clk         (clk),
        .rstN        (rstN),
        .issue       (issue),
        .instr       (instr),
        .a           (a),
        .i           (i),
        .lr          (lr),
        .tvec        (tvec),
        .waitCtr     (waitCtr),
        .pc          (pc),
        .im          (im),
        .ol          (ol),
        .opBus       (opBus.ctrl),
        .calcBus     (calcBus),
        .branchTaken (branchTaken),
        .nextTarget  (nextTarget),
        .done        (done),
        .result      (result),
        .taken       (taken),
        .target      (target),
        .illegal     (illegal)
    );

    // ========================================
    // Datapaths
    // ========================================

    fcuCalc calc (
        .opBus (opBus.dp),
        .bus   (calcBus)
    );

    fcuBranchEval branchEval (
        .opBus (opBus.dp),
        .taken (branchTaken)
    );

    fcuTarget targetCalc (
        .opBus  (opBus.dp),
        .target (nextTarget)
    );

endmodule

`default_nettype wire

//--- testbench/fcuTb.sv
`timescale 1ns/10ps
`default_nettype none

module fcuTb
    import fcuPkg::*;
();

    localparam int cycleLimit = 1200;
    localparam logic [31:0] dirPc   = 32'h0000_1000;
    localparam logic [63:0] dirLr   = 64'h1234_5678_9ABC_DEF0;
    localparam logic [63:0] dirTvec = 64'h0000_0000_0000_0F00;
    // Result expected for an undefined function, 0xCC in every byte
    localparam logic [63:0] fillExp = 64'hCCCC_CCCC_CCCC_CCCC;

    // One expected response per issued instruction
    typedef struct packed {
        logic [63:0] result;
        logic        taken;
        logic [31:0] target;
        logic        illegal;
    } expectRec;

    logic        clk;
    logic        rstN;
    logic        issue;
    logic [47:0] instr;
    logic [63:0] a, i, lr, tvec, waitCtr;
    logic [31:0] pc;
    logic [2:0]  im;
    opLevel      ol;
    logic        done, taken, illegal;
    logic [63:0] result;
    logic [31:0] target;

    expectRec expQ[$];
    logic     issueAt1, issueAt2;
    int       cycles;

    fcuTop UUT (
        .clk(clk), .rstN(rstN), .issue(issue), .instr(instr), .a(a), .i(i), .lr(lr),
        .tvec(tvec), .waitCtr(waitCtr), .pc(pc), .im(im), .ol(ol), .done(done),
        .result(result), .taken(taken), .target(target), .illegal(illegal)
    );

    // ========================================
    // Failure reporting
    // ========================================

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        failRun($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, expVal, actVal));
    endtask

    // ========================================
    // Reference model
    // ========================================

    function automatic expectRec expectedFor(input logic [47:0] ins, input logic [63:0] aV,
        input logic [63:0] iV, lrV, tvecV, waitV, input logic [31:0] pcV,
        input logic [2:0] imV, input logic [1:0] olV);
        expectRec e;
        logic [31:0] disp;
        logic [31:0] link;
        // Undefined until a rule below claims the opcode
        e = '{result: fillExp, taken: 1'b0, target: 32'h0, illegal: 1'b1};
        disp = {{16{ins[47]}}, ins[47:32]};
        link = pcV + (ins[6] ? 32'd6 : 32'd4);
        case (ins[5:0])
            opBrk:
                e = '{result: {56'h0, ins[15:8]}, taken: 1'b1, target: tvecV[31:0], illegal: 1'b0};
            opBbc:
            begin
                if (ins[19:17] == subIbne)
                    e = '{result: aV + 64'd1, taken: (aV + 64'd1) != iV,
                          target: pcV + disp, illegal: 1'b0};
                else if (ins[19:17] == subDbnz)
                    e = '{result: aV - 64'd1, taken: (aV - 64'd1) != 64'd0,
                          target: pcV + disp, illegal: 1'b0};
            end
            opJal:
                e = '{result: {32'h0, link}, taken: 1'b1, target: aV[31:0] + disp, illegal: 1'b0};
            opCall:
                e = '{result: {32'h0, link}, taken: 1'b1, target: ins[47:16], illegal: 1'b0};
            opRet:
                e = '{result: aV + iV, taken: 1'b1, target: lrV[31:0], illegal: 1'b0};
            opRex:
            begin
                // Mask limit is 3 minus the level, user level has none
                if (olV != 2'd3)
                    e = '{result: {32'h0, pcV + 32'd4}, taken: 1'b1, illegal: 1'b0,
                          target: (imV < {1'b0, 2'd3 - olV}) ? tvecV[31:0] : pcV + 32'd4};
            end
            opWait:
                e = '{result: (waitV == 64'd1) ? 64'd1 : 64'd0, taken: waitV != 64'd1,
                      target: pcV, illegal: 1'b0};
        endcase
        return e;
    endfunction

    function automatic logic [47:0] buildInstr(input logic [5:0] op, input logic [2:0] sub,
                                               input logic lng, input logic [15:0] disp);
        return {disp, 12'h0, sub, 10'h0, lng, op};
    endfunction

    // ========================================
    // Stimulus
    // ========================================

    task automatic issueOne(input logic [47:0] insV, input logic [63:0] aV, iV, lrV, tvecV,
        waitV, input logic [31:0] pcV, input logic [2:0] imV, input logic [1:0] olV);
        issue = 1'b1;
        instr = insV;
        a = aV;
        i = iV;
        lr = lrV;
        tvec = tvecV;
        waitCtr = waitV;
        pc = pcV;
        im = imV;
        ol = opLevel'(olV);
        expQ.push_back(expectedFor(insV, aV, iV, lrV, tvecV, waitV, pcV, imV, olV));
        @(posedge clk);
        #1;
        issue = 1'b0;
    endtask

    // Directed form with fixed link, vector and pc
    task automatic issueDirected(input logic [47:0] insV, input logic [63:0] aV, iV, waitV,
                                 input logic [2:0] imV, input logic [1:0] olV);
        issueOne(insV, aV, iV, dirLr, dirTvec, waitV, dirPc, imV, olV);
    endtask

    task automatic issueRandom();
        logic [63:0] r;
        logic [47:0] ins;
        logic [63:0] aV;
        logic [63:0] iV;
        r = {$urandom, $urandom};
        ins = r[47:0];
        case ($urandom_range(0, 9))
            0: ins[5:0] = opBrk;
            // Sub-function 5 is not handled, 6 and 7 are
            1, 2:
            begin
                ins[5:0] = opBbc;
                ins[19:17] = 3'($urandom_range(5, 7));
            end
            3: ins[5:0] = opJal;
            4: ins[5:0] = opCall;
            5: ins[5:0] = opRet;
            6, 7: ins[5:0] = opRex;
            8: ins[5:0] = opWait;
            default: ins[5:0] = 6'($urandom);
        endcase
        aV = {$urandom, $urandom};
        if ($urandom_range(0, 3) == 0)
            aV = 64'($urandom_range(0, 2));
        iV = {$urandom, $urandom};
        // Hit the not-taken IBNE case now and then
        if ($urandom_range(0, 3) == 0)
            iV = aV + 64'd1;
        issueOne(ins, aV, iV, {$urandom, $urandom}, {$urandom, $urandom},
                 64'($urandom_range(0, 3)), $urandom, 3'($urandom_range(0, 7)),
                 2'($urandom_range(0, 3)));
    endtask

    task automatic idleCycles(input int n);
        if (n > 0)
        begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    // ========================================
    // Clock, checks and timeout
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs settle long before the falling edge
    always @(negedge clk)
    begin
        expectRec e;
        if (rstN)
        begin
            assert (done === issueAt2)
            else reportMismatch("done", 64'(issueAt2), 64'(done));
            if (done === 1'b1)
            begin
                e = expQ.pop_front();
                assert (result === e.result)
                else reportMismatch("result", e.result, result);
                assert (taken === e.taken)
                else reportMismatch("taken", 64'(e.taken), 64'(taken));
                assert (target === e.target)
                else reportMismatch("target", 64'(e.target), 64'(target));
                assert (illegal === e.illegal)
                else reportMismatch("illegal", 64'(e.illegal), 64'(illegal));
            end
        end
        issueAt2 = issueAt1;
        issueAt1 = issue;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit)
            failRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
    end

    initial
    begin
        void'($urandom(32'hb57c_38aa));
        cycles = 0;
        issueAt1 = 1'b0;
        issueAt2 = 1'b0;
        rstN = 1'b0;
        issue = 1'b0;
        instr = '0;
        a = '0;
        i = '0;
        lr = '0;
        tvec = '0;
        waitCtr = '0;
        pc = '0;
        im = '0;
        ol = olMachine;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        idleCycles(2);

        // Directed cases, issued back to back
        issueDirected(buildInstr(opBrk, 3'd0, 1'b0, 16'h0) | 48'h5A00, 0, 0, 0, 0, 0);
        issueDirected(buildInstr(opBbc, subIbne, 1'b0, 16'hFFF0), '1, 64'd0, 0, 0, 0);
        issueDirected(buildInstr(opBbc, subIbne, 1'b0, 16'hFFF0), '1, 64'd3, 0, 0, 0);
        issueDirected(buildInstr(opBbc, subDbnz, 1'b0, 16'h0040), 64'd1, 0, 0, 0, 0);
        issueDirected(buildInstr(opBbc, subDbnz, 1'b0, 16'h0040), 64'd0, 0, 0, 0, 0);
        issueDirected(buildInstr(opJal, 3'd0, 1'b0, 16'hFF00), 64'h2000, 0, 0, 0, 0);
        issueDirected(buildInstr(opJal, 3'd0, 1'b1, 16'h0010), 64'h2000, 0, 0, 0, 0);
        issueDirected(buildInstr(opCall, 3'd0, 1'b1, 16'h0008), 0, 0, 0, 0, 0);
        issueDirected(buildInstr(opCall, 3'd0, 1'b0, 16'h0004), 0, 0, 0, 0, 0);
        issueDirected(buildInstr(opRet, 3'd0, 1'b0, 16'h0), 64'h8000, 64'h18, 0, 0, 0);
        issueDirected(buildInstr(opWait, 3'd0, 1'b0, 16'h0), 0, 0, 64'd1, 0, 0);
        issueDirected(buildInstr(opWait, 3'd0, 1'b0, 16'h0), 0, 0, 64'd7, 0, 0);
        // REX with the mask just below and at the level limit
        for (int lvl = 0; lvl < 3; lvl++)
        begin
            issueDirected(buildInstr(opRex, 3'd0, 1'b0, 16'h0), 0, 0, 0, 3'(2 - lvl), 2'(lvl));
            issueDirected(buildInstr(opRex, 3'd0, 1'b0, 16'h0), 0, 0, 0, 3'(3 - lvl), 2'(lvl));
        end
        issueDirected(buildInstr(opRex, 3'd0, 1'b0, 16'h0), 0, 0, 0, 3'd0, 2'd3);
        issueDirected(buildInstr(6'h3F, 3'd0, 1'b0, 16'h0), 0, 0, 0, 0, 0);
        issueDirected(buildInstr(opBbc, 3'd1, 1'b0, 16'h0), 0, 0, 0, 0, 0);
        idleCycles(3);

        repeat (400)
        begin
            issueRandom();
            idleCycles($urandom_range(0, 1));
        end

        // Let the pipeline drain
        while (expQ.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ft64Fcu.f
hw/fcuPkg.sv
hw/fcuOpIf.sv
hw/fcuControl.sv
hw/fcuCalc.sv
hw/fcuBranchEval.sv
hw/fcuTarget.sv
hw/fcuTop.sv
testbench/fcuTb.sv

//--- build.sh
#!/bin/sh
# Build and run the FCU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f ft64Fcu.f --top-module fcuTb \
    --Mdir obj_dir -o fcuTbSim

# Exit status of the simulation decides pass or fail
./obj_dir/fcuTbSim
